//--- filelist.f
+incdir+src
+incdir+tests
src/md5Types_pkg.sv
src/md5Rounds_pkg.sv
src/md5RoundLogic.sv
src/md5Step.sv
src/md5Finalize.sv
src/md5Top.sv
tests/md5Top_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the MD5 pipeline testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir && \
verilator --binary --timing --assert -j 0 -f filelist.f \
  --top-module md5Top_tb -o md5Sim \
  || { echo "Build failed"; exit 1; }

simOutput="$(./obj_dir/md5Sim)"
echo "$simOutput"
echo "$simOutput" | grep -qx "Test passed" \
  && { echo "RESULT: pass"; exit 0; } \
  || { echo "RESULT: fail"; exit 1; }

//--- tests/md5RefModel.svh
`ifndef MD5_REF_MODEL_SVH
`define MD5_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Software MD5 compression
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// floor(abs(sin(step + 1)) * 2^32), straight from the definition
function automatic md5Word_t sineConstant(int step);
  real s;
  s = $sin(real'(step + 1));
  if (s < 0.0)
    s = -s;
  return md5Word_t'(longint'($floor(s * 4294967296.0)));
endfunction

function automatic int rotateAmount(int step);
  int amounts [4];
  case (step / 16)
    0:       amounts = '{7, 12, 17, 22};
    1:       amounts = '{5, 9, 14, 20};
    2:       amounts = '{4, 11, 16, 23};
    default: amounts = '{6, 10, 15, 21};
  endcase
  return amounts[step % 4];
endfunction

// Message word used by each step
function automatic int wordIndex(int step);
  case (step / 16)
    0:       return step;
    1:       return (5 * step + 1) % 16;
    2:       return (3 * step + 5) % 16;
    default: return (7 * step) % 16;
  endcase
endfunction

function automatic md5Word_t mixBits(int step, md5Word_t b, md5Word_t c, md5Word_t d);
  case (step / 16)
    0:       return (b & c) | (~b & d);
    1:       return (d & b) | (~d & c);
    2:       return b ^ c ^ d;
    default: return c ^ (b | ~d);
  endcase
endfunction

function automatic md5Word_t rotateLeft(md5Word_t x, int n);
  return (x << n) | (x >> (32 - n));
endfunction

function automatic md5State_t md5Compress(md5Block_u blk, md5State_t init);
  md5Word_t  a;
  md5Word_t  b;
  md5Word_t  c;
  md5Word_t  d;
  md5Word_t  t;
  md5State_t result;
  a = init.a;
  b = init.b;
  c = init.c;
  d = init.d;
  for (int i = 0; i < 64; i++)
  begin
    t = a + mixBits(i, b, c, d) + sineConstant(i) + blk.words[wordIndex(i)];
    a = d;
    d = c;
    c = b;
    b = b + rotateLeft(t, rotateAmount(i));
  end
  // Chaining value added back
  result.a = init.a + a;
  result.b = init.b + b;
  result.c = init.c + c;
  result.d = init.d + d;
  return result;
endfunction

`endif

//--- tests/md5Top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_settings.svh"

module md5Top_tb;

  import md5Types_pkg::*;

  `include "md5RefModel.svh"

  localparam int clkPeriod   = 100;
  localparam int latency     = `MD5_STEP_COUNT + 1;
  localparam int resetCycles = 3;
  localparam int idleCycles  = 70;
  localparam int burstItems  = 150;
  localparam int gapItems    = 100;

  // Gap phase budgeted at three cycles per item
  localparam int drivenCycles =
    resetCycles + idleCycles + latency + 10 + burstItems + 3 * gapItems;
  localparam int watchdogCycles = drivenCycles + latency + 20;

  localparam md5State_t stdInit = '{
    a: 32'h67452301, b: 32'hefcdab89, c: 32'h98badcfe, d: 32'h10325476
  };
  localparam md5State_t emptyDigest = '{
    a: 32'hd98c1dd4, b: 32'h04b2008f, c: 32'h980980e9, d: 32'h7e42f8ec
  };

  logic      clk = 1'b0;
  logic      rstN;
  logic      inValid;
  md5Block_u block;
  md5State_t initState;
  logic      outValid;
  md5State_t digest;

  integer    seed = 23957;
  int        errorCount = 0;
  int        checkedCount = 0;
  md5State_t expectedQ [$];
  logic      validHistory [$];
  logic      expectValid;
  md5State_t expectDigest;

  md5Top i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .block    (block),
    .initState(initState),
    .outValid (outValid),
    .digest   (digest)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected results
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Inputs are stable at the rising edge
  always @(posedge clk)
  begin
    validHistory.push_back(inValid);
    if (inValid)
      expectedQ.push_back(md5Compress(block, initState));
  end

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    expectValid = 1'b0;
    if (validHistory.size() >= latency)
      expectValid = validHistory.pop_front();
    if (outValid !== expectValid)
    begin
      $display("[ERROR] outValid expected %h actual %h at %0t", expectValid, outValid, $time);
      errorCount++;
    end
    if (outValid === 1'b1)
    begin
      if (expectedQ.size() == 0)
      begin
        $display("Output strobe at %0t with no block outstanding", $time);
        errorCount++;
      end
      else
      begin
        expectDigest = expectedQ.pop_front();
        checkedCount++;
        if (digest !== expectDigest)
        begin
          $display("[ERROR] digest expected %h actual %h at %0t", expectDigest, digest, $time);
          errorCount++;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic md5Block_u emptyStringBlock();
    md5Block_u blk;
    blk = '0;
    blk.words[0] = 32'h00000080;
    return blk;
  endfunction

  function automatic md5Block_u randomBlock();
    md5Block_u blk;
    for (int i = 0; i < `MD5_BLOCK_WORDS; i++)
      blk.words[i] = $random(seed);
    return blk;
  endfunction

  function automatic md5State_t randomState();
    md5State_t st;
    st.a = $random(seed);
    st.b = $random(seed);
    st.c = $random(seed);
    st.d = $random(seed);
    return st;
  endfunction

  task automatic checkModelVector();
    md5State_t got;
    got = md5Compress(emptyStringBlock(), stdInit);
    if (got !== emptyDigest)
    begin
      $display("[ERROR] model digest expected %h actual %h", emptyDigest, got);
      errorCount++;
    end
  endtask

  task automatic driveIdle(int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      inValid = 1'b0;
    end
  endtask

  // Known vector through an empty pipeline, also measures latency
  task automatic checkIsolatedItem();
    int cycles;
    @(negedge clk);
    inValid = 1'b1;
    block = emptyStringBlock();
    initState = stdInit;
    @(negedge clk);
    inValid = 1'b0;
    cycles = 1;
    while (outValid !== 1'b1 && cycles < latency + 10)
    begin
      @(negedge clk);
      cycles++;
    end
    if (outValid !== 1'b1)
    begin
      $display("No output strobe within %0d cycles of the isolated block", cycles);
      errorCount++;
    end
    else
    begin
      if (cycles != latency)
      begin
        $display("[ERROR] outValid latency expected %h actual %h", latency, cycles);
        errorCount++;
      end
      if (digest !== emptyDigest)
      begin
        $display("[ERROR] digest expected %h actual %h", emptyDigest, digest);
        errorCount++;
      end
    end
  endtask

  task automatic driveBurst(int count);
    repeat (count)
    begin
      @(negedge clk);
      inValid = 1'b1;
      block = randomBlock();
      initState = randomState();
    end
  endtask

  task automatic driveWithGaps(int count);
    int     sent;
    integer coin;
    sent = 0;
    while (sent < count)
    begin
      @(negedge clk);
      coin = $random(seed);
      inValid = coin[0];
      block = randomBlock();
      initState = randomState();
      if (coin[0])
        sent++;
    end
  endtask

  task automatic drainPipeline();
    int waited;
    @(negedge clk);
    inValid = 1'b0;
    waited = 0;
    // Queue only shrinks on falling edges
    while (expectedQ.size() != 0 && waited < latency + 10)
    begin
      @(posedge clk);
      waited++;
    end
    repeat (5)
      @(negedge clk);
  endtask

  initial
  begin
    rstN = 1'b0;
    inValid = 1'b0;
    block = '0;
    initState = '0;
    checkModelVector();
    repeat (resetCycles)
      @(negedge clk);
    rstN = 1'b1;
    driveIdle(idleCycles);
    checkIsolatedItem();
    driveBurst(burstItems);
    driveWithGaps(gapItems);
    drainPipeline();
    if (expectedQ.size() != 0)
    begin
      $display("%0d expected digests never came out of the pipeline", expectedQ.size());
      errorCount++;
    end
    $display("Summary: %0d digests checked, %0d errors", checkedCount, errorCount);
    if (errorCount == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("Summary: %0d digests checked, %0d errors", checkedCount, errorCount);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/md5Top.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_settings.svh"

module md5Top (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire                     inValid,
  input  md5Types_pkg::md5Block_u block,
  input  md5Types_pkg::md5State_t initState,
  output logic                    outValid,
  output md5Types_pkg::md5State_t digest
);

  import md5Types_pkg::*;

  // Bundle entering step i is stageChain[i]
  md5Stage_t stageChain [0:`MD5_STEP_COUNT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input bundle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Working state starts from the chaining value
  assign stageChain[0] = '{
    valid: inValid,
    state: initState,
    chain: initState,
    block: block
  };

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // 64 step pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < `MD5_STEP_COUNT; i++)
  begin : genStep
    md5Step #(
      .stepIndex(i)
    ) step (
      .clk     (clk),
      .rstN    (rstN),
      .stageIn (stageChain[i]),
      .stageOut(stageChain[i+1])
    );
  end

  // One more register for the chaining add
  md5Finalize finalize (
    .clk     (clk),
    .rstN    (rstN),
    .stageIn (stageChain[`MD5_STEP_COUNT]),
    .outValid(outValid),
    .digest  (digest)
  );

endmodule

`default_nettype wire

//--- src/md5Finalize.sv
`timescale 1ns/1ps
`default_nettype none

module md5Finalize (
  input  wire                     clk,
  input  wire                     rstN,
  input  md5Types_pkg::md5Stage_t stageIn,
  output logic                    outValid,
  output md5Types_pkg::md5State_t digest
);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      outValid <= 1'b0;
    else
      outValid <= stageIn.valid;
  end

  // Feed-forward of the chaining value, mod 2^32 per word
  always_ff @(posedge clk)
  begin
    digest.a <= stageIn.chain.a + stageIn.state.a;
    digest.b <= stageIn.chain.b + stageIn.state.b;
    digest.c <= stageIn.chain.c + stageIn.state.c;
    digest.d <= stageIn.chain.d + stageIn.state.d;
  end

  // An X here means some stage upstream lost its reset
  outValidKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    !$isunknown(outValid)
  );

endmodule

`default_nettype wire

//--- src/md5Step.sv
`timescale 1ns/1ps
`default_nettype none

module md5Step #(
  parameter int stepIndex = 0
) (
  input  wire                     clk,
  input  wire                     rstN,
  input  md5Types_pkg::md5Stage_t stageIn,
  output md5Types_pkg::md5Stage_t stageOut
);

  import md5Types_pkg::*;

  md5Word_t  newB;

  logic      validQ;
  md5State_t stateQ;
  md5State_t chainQ;
  md5Block_u blockQ;

  md5RoundLogic #(
    .stepIndex(stepIndex)
  ) roundLogic (
    .state(stageIn.state),
    .block(stageIn.block),
    .newB (newB)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      validQ <= 1'b0;
    else
      validQ <= stageIn.valid;
  end

  // Working words shift one place, b takes the new value
  always_ff @(posedge clk)
  begin
    stateQ.a <= stageIn.state.d;
    stateQ.b <= newB;
    stateQ.c <= stageIn.state.b;
    stateQ.d <= stageIn.state.c;
    chainQ   <= stageIn.chain;
    blockQ   <= stageIn.block;
  end

  assign stageOut = '{valid: validQ, state: stateQ, chain: chainQ, block: blockQ};

  // A valid bundle never leaves with unknown working words
  validStateKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    stageOut.valid |-> !$isunknown(stageOut.state)
  );

endmodule

`default_nettype wire

//--- src/md5RoundLogic.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_settings.svh"

module md5RoundLogic #(
  parameter int stepIndex = 0
) (
  input  md5Types_pkg::md5State_t state,
  input  md5Types_pkg::md5Block_u block,
  output md5Types_pkg::md5Word_t  newB
);

  import md5Types_pkg::*;
  import md5Rounds_pkg::*;

  // Fixed per stage, resolved at elaboration
  localparam md5Round_e roundSel  = md5RoundOf(stepIndex);
  localparam int        msgIndex  = md5MessageIndex(stepIndex);
  localparam md5Word_t  stepConst = md5StepConstant(stepIndex);
  localparam int        rotAmount = int'(md5ShiftAmount(stepIndex));

  md5Word_t funcOut;
  md5Word_t sum;
  md5Word_t rotated;

  always_comb
  begin
    case (roundSel)
      roundF:  funcOut = (state.b & state.c) | (~state.b & state.d);
      roundG:  funcOut = (state.b & state.d) | (state.c & ~state.d);
      roundH:  funcOut = state.b ^ state.c ^ state.d;
      default: funcOut = state.c ^ (state.b | ~state.d);
    endcase
  end

  assign sum = state.a + funcOut + stepConst + block.words[msgIndex];

  // Rotate left
  assign rotated = (sum << rotAmount) | (sum >> (`MD5_WORD_WIDTH - rotAmount));

  assign newB = state.b + rotated;

endmodule

`default_nettype wire

//--- src/md5Rounds_pkg.sv
`default_nettype none

`include "md5_settings.svh"

package md5Rounds_pkg;

  import md5Types_pkg::*;

  typedef enum logic [1:0] {
    roundF,
    roundG,
    roundH,
    roundI
  } md5Round_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Constant tables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // floor(abs(sin(i + 1)) * 2^32)
  localparam md5Word_t sineTable [0:`MD5_STEP_COUNT-1] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // Rotate amounts repeat every four steps within a round
  localparam logic [4:0] shiftTable [0:3][0:3] = '{
    '{5'd7, 5'd12, 5'd17, 5'd22},
    '{5'd5, 5'd9,  5'd14, 5'd20},
    '{5'd4, 5'd11, 5'd16, 5'd23},
    '{5'd6, 5'd10, 5'd15, 5'd21}
  };

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-step decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic md5Round_e md5RoundOf(int step);
    return md5Round_e'(2'(step / `MD5_BLOCK_WORDS));
  endfunction

  function automatic int md5MessageIndex(int step);
    int idx;
    case (md5RoundOf(step))
      roundF:  idx = step;
      roundG:  idx = 5 * step + 1;
      roundH:  idx = 3 * step + 5;
      default: idx = 7 * step;
    endcase
    return idx % `MD5_BLOCK_WORDS;
  endfunction

  function automatic md5Word_t md5StepConstant(int step);
    return sineTable[step];
  endfunction

  function automatic logic [4:0] md5ShiftAmount(int step);
    int roundIdx;
    roundIdx = step / `MD5_BLOCK_WORDS;
    return shiftTable[roundIdx][step % 4];
  endfunction

endpackage

`default_nettype wire

//--- src/md5Types_pkg.sv
`default_nettype none

`include "md5_settings.svh"

package md5Types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Words and state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`MD5_WORD_WIDTH-1:0] md5Word_t;

  typedef struct packed {
    md5Word_t a;
    md5Word_t b;
    md5Word_t c;
    md5Word_t d;
  } md5State_t;

  // Same 512 bits, seen as a bus vector or as message words
  // Word 0 sits in the low bits
  typedef union packed {
    logic [`MD5_BLOCK_WORDS*`MD5_WORD_WIDTH-1:0] flat;
    md5Word_t [`MD5_BLOCK_WORDS-1:0]             words;
  } md5Block_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline bundle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic      valid;
    md5State_t state;
    // Chaining value, added back at the end
    md5State_t chain;
    md5Block_u block;
  } md5Stage_t;

endpackage

`default_nettype wire

//--- src/md5_settings.svh
`ifndef MD5_SETTINGS_SVH
`define MD5_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MD5 geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Bits per MD5 word
`define MD5_WORD_WIDTH 32

// Words per 512-bit message block, also steps per round
`define MD5_BLOCK_WORDS 16

`define MD5_STEP_COUNT 64

`endif
